// ==== source/core_settings.svh ====
/*
 * mini core settings
 * data width, register count, boot address and trap cause
 */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data path and pc width
`define XLEN_W 32

// architectural registers, x0 included
`define NR_REGS 32

// pc of the first accepted instruction
`define BOOT_ADDR 32'h0000_1000

// cause reported for an illegal instruction
`define CAUSE_ILLEGAL 2

`endif

// ==== source/core_pkg.sv ====
/*
 * mini core package
 * shared vector types and the ALU operation encoding
 */
`include "core_settings.svh"

package core_pkg;

  // ----------------------------------------
  // data path types
  // ----------------------------------------

  // one register value or ALU result
  typedef logic [`XLEN_W-1:0] xlen_t;

  // program counter
  typedef logic [`XLEN_W-1:0] addr_t;

  // raw RV32I instruction word
  typedef logic [31:0] instr_t;

  // register file index
  typedef logic [$clog2(`NR_REGS)-1:0] reg_idx_t;

  // exception cause as reported on retire
  typedef logic [3:0] cause_t;

  // ----------------------------------------
  // ALU operations
  // ----------------------------------------

  // register-register and register-immediate forms share one encoding
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    // passes operand b through, for LUI
    ALU_LUI
  } alu_op_e;

endpackage

// ==== source/stage_if.sv ====
/*
 * stage interfaces
 * decode to execute, register file read, execute to commit
 */
`timescale 1ns/1ps

// decoded instruction handed to execute, no back-pressure
interface dec_exe_if;
  import core_pkg::*;

  logic     valid;
  alu_op_e  op;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  xlen_t    imm;
  logic     use_imm;
  addr_t    pc;
  logic     illegal;
  instr_t   instr;

  modport out (output valid, op, rd, rs1, rs2, imm, use_imm, pc, illegal, instr);
  modport in  (input  valid, op, rd, rs1, rs2, imm, use_imm, pc, illegal, instr);
endinterface

// two combinational read ports into the register file
interface rf_read_if;
  import core_pkg::*;

  reg_idx_t rs1_addr;
  reg_idx_t rs2_addr;
  xlen_t    rs1_data;
  xlen_t    rs2_data;

  modport requester (output rs1_addr, rs2_addr, input  rs1_data, rs2_data);
  modport responder (input  rs1_addr, rs2_addr, output rs1_data, rs2_data);
endinterface

// executed instruction handed to commit
interface exe_com_if;
  import core_pkg::*;

  logic     valid;
  logic     wen;
  logic     exc;
  reg_idx_t rd;
  xlen_t    result;
  addr_t    pc;
  instr_t   tval;

  modport out (output valid, wen, exc, rd, result, pc, tval);
  modport in  (input  valid, wen, exc, rd, result, pc, tval);
endinterface

// ==== source/decode_stage.sv ====
/*
 * decode stage
 * accepts instructions, counts the pc and decodes OP, OP-IMM and LUI
 */
`timescale 1ns/1ps
`include "core_settings.svh"

module decode_stage (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            instr_valid_i,
  input  core_pkg::instr_t instr_i,
  output logic            instr_ready_o,
  dec_exe_if.out          dec_o
);
  import core_pkg::*;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  logic       ready_q;
  logic [1:0] drain_q;
  addr_t      pc_q;
  logic       accept;

  alu_op_e    d_op;
  xlen_t      d_imm;
  logic       d_use_imm;
  logic       d_illegal;
  logic [6:0] funct7;
  logic [2:0] funct3;

  assign accept        = instr_valid_i & ready_q;
  assign instr_ready_o = ready_q;
  assign funct7        = instr_i[31:25];
  assign funct3        = instr_i[14:12];

  // ----------------------------------------
  // handshake and pc
  // ----------------------------------------

  // an illegal instruction holds ready low until it retires
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_q <= 1'b0;
      drain_q <= 2'd0;
      pc_q    <= `BOOT_ADDR;
    end else begin
      if (accept && d_illegal) begin
        drain_q <= 2'd2;
        ready_q <= 1'b0;
      end else if (drain_q != 2'd0) begin
        drain_q <= drain_q - 2'd1;
        ready_q <= (drain_q == 2'd1);
      end else begin
        ready_q <= 1'b1;
      end
      if (accept) begin
        pc_q <= pc_q + addr_t'(4);
      end
    end
  end

  // ----------------------------------------
  // instruction decoding
  // ----------------------------------------

  always_comb begin
    d_op      = ALU_ADD;
    d_imm     = {{(`XLEN_W-12){instr_i[31]}}, instr_i[31:20]};
    d_use_imm = 1'b0;
    d_illegal = 1'b1;
    case (instr_i[6:0])
      OPC_OP: begin
        d_illegal = 1'b0;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: d_op = ALU_ADD;
          {7'b0100000, 3'b000}: d_op = ALU_SUB;
          {7'b0000000, 3'b001}: d_op = ALU_SLL;
          {7'b0000000, 3'b010}: d_op = ALU_SLT;
          {7'b0000000, 3'b011}: d_op = ALU_SLTU;
          {7'b0000000, 3'b100}: d_op = ALU_XOR;
          {7'b0000000, 3'b101}: d_op = ALU_SRL;
          {7'b0100000, 3'b101}: d_op = ALU_SRA;
          {7'b0000000, 3'b110}: d_op = ALU_OR;
          {7'b0000000, 3'b111}: d_op = ALU_AND;
          default:              d_illegal = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        d_use_imm = 1'b1;
        d_illegal = 1'b0;
        case (funct3)
          3'b000: d_op = ALU_ADD;
          3'b010: d_op = ALU_SLT;
          3'b011: d_op = ALU_SLTU;
          3'b100: d_op = ALU_XOR;
          3'b110: d_op = ALU_OR;
          3'b111: d_op = ALU_AND;
          3'b001: begin
            d_op      = ALU_SLL;
            d_illegal = (funct7 != 7'b0000000);
          end
          default: begin
            // shift right, funct7 picks arithmetic or logical
            d_op      = (funct7[5]) ? ALU_SRA : ALU_SRL;
            d_illegal = ({funct7[6], funct7[4:0]} != 6'b0);
          end
        endcase
      end
      OPC_LUI: begin
        d_op      = ALU_LUI;
        d_imm     = {instr_i[31:12], 12'b0};
        d_use_imm = 1'b1;
        d_illegal = 1'b0;
      end
      default: d_illegal = 1'b1;
    endcase
  end

  // ----------------------------------------
  // decode register
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_o.valid <= 1'b0;
    end else begin
      dec_o.valid <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_o.op      <= d_op;
      dec_o.rd      <= instr_i[11:7];
      dec_o.rs1     <= instr_i[19:15];
      dec_o.rs2     <= instr_i[24:20];
      dec_o.imm     <= d_imm;
      dec_o.use_imm <= d_use_imm;
      dec_o.pc      <= pc_q;
      dec_o.illegal <= d_illegal;
      dec_o.instr   <= instr_i;
    end
  end

endmodule

// ==== source/execute_stage.sv ====
/*
 * execute stage
 * operand select with one bypass, the ALU and the execute register
 */
`timescale 1ns/1ps

module execute_stage (
  input  logic         clk_i,
  input  logic         rst_ni,
  dec_exe_if.in        dec_i,
  rf_read_if.requester rf_o,
  exe_com_if.out       com_o
);
  import core_pkg::*;

  logic       fwd_rs1;
  logic       fwd_rs2;
  xlen_t      rs1_val;
  xlen_t      rs2_val;
  xlen_t      op_a;
  xlen_t      op_b;
  xlen_t      alu_res;
  logic [4:0] shamt;
  logic       legal_wr;

  // ----------------------------------------
  // operands
  // ----------------------------------------

  assign rf_o.rs1_addr = dec_i.rs1;
  assign rf_o.rs2_addr = dec_i.rs2;

  // the instruction one ahead has not reached the register file yet
  assign fwd_rs1 = com_o.valid & com_o.wen & (com_o.rd == dec_i.rs1);
  assign fwd_rs2 = com_o.valid & com_o.wen & (com_o.rd == dec_i.rs2);

  assign rs1_val = fwd_rs1 ? com_o.result : rf_o.rs1_data;
  assign rs2_val = fwd_rs2 ? com_o.result : rf_o.rs2_data;

  assign op_a  = rs1_val;
  assign op_b  = dec_i.use_imm ? dec_i.imm : rs2_val;
  assign shamt = op_b[4:0];

  // ----------------------------------------
  // ALU
  // ----------------------------------------

  always_comb begin
    case (dec_i.op)
      ALU_ADD:  alu_res = op_a + op_b;
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_AND:  alu_res = op_a & op_b;
      ALU_OR:   alu_res = op_a | op_b;
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SLT:  alu_res = xlen_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU: alu_res = xlen_t'(op_a < op_b);
      ALU_SLL:  alu_res = op_a << shamt;
      ALU_SRL:  alu_res = op_a >> shamt;
      ALU_SRA:  alu_res = xlen_t'($signed(op_a) >>> shamt);
      ALU_LUI:  alu_res = op_b;
      default:  alu_res = '0;
    endcase
  end

  // ----------------------------------------
  // execute register
  // ----------------------------------------

  // x0 is never written, so it never needs a bypass either
  assign legal_wr = dec_i.valid & ~dec_i.illegal & (dec_i.rd != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      com_o.valid <= 1'b0;
      com_o.wen   <= 1'b0;
      com_o.exc   <= 1'b0;
    end else begin
      com_o.valid <= dec_i.valid;
      com_o.wen   <= legal_wr;
      com_o.exc   <= dec_i.valid & dec_i.illegal;
    end
  end

  always_ff @(posedge clk_i) begin
    com_o.rd     <= dec_i.rd;
    com_o.result <= alu_res;
    com_o.pc     <= dec_i.pc;
    // trap value carries the offending instruction word
    com_o.tval   <= dec_i.illegal ? dec_i.instr : '0;
  end

endmodule

// ==== source/commit_stage.sv ====
/*
 * commit stage
 * register file, retire port and the instret counter
 */
`timescale 1ns/1ps
`include "core_settings.svh"

module commit_stage (
  input  logic              clk_i,
  input  logic              rst_ni,
  exe_com_if.in             com_i,
  rf_read_if.responder      rf_i,
  output logic              retire_valid_o,
  output logic              retire_exc_o,
  output core_pkg::addr_t   retire_pc_o,
  output core_pkg::reg_idx_t retire_rd_o,
  output core_pkg::xlen_t   retire_wdata_o,
  output core_pkg::instr_t  retire_tval_o,
  output core_pkg::cause_t  retire_cause_o,
  output core_pkg::xlen_t   instret_o
);
  import core_pkg::*;

  // x0 is hardwired, only the writable registers are stored
  xlen_t regs_q [1:`NR_REGS-1];
  logic  retire_ok;

  assign retire_ok = com_i.valid & ~com_i.exc;

  // ----------------------------------------
  // register file
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (com_i.valid && com_i.wen) begin
      regs_q[com_i.rd] <= com_i.result;
    end
  end

  assign rf_i.rs1_data = (rf_i.rs1_addr == '0) ? '0 : regs_q[rf_i.rs1_addr];
  assign rf_i.rs2_data = (rf_i.rs2_addr == '0) ? '0 : regs_q[rf_i.rs2_addr];

  // ----------------------------------------
  // retire port
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      retire_valid_o <= 1'b0;
      retire_exc_o   <= 1'b0;
      instret_o      <= '0;
    end else begin
      retire_valid_o <= com_i.valid;
      retire_exc_o   <= com_i.valid & com_i.exc;
      if (retire_ok) begin
        instret_o <= instret_o + xlen_t'(1);
      end
    end
  end

  // fields hold their last value between retires
  always_ff @(posedge clk_i) begin
    if (com_i.valid) begin
      retire_pc_o   <= com_i.pc;
      retire_tval_o <= com_i.tval;
      if (com_i.exc) begin
        // an exception writes nothing
        retire_rd_o    <= '0;
        retire_wdata_o <= '0;
        retire_cause_o <= cause_t'(`CAUSE_ILLEGAL);
      end else begin
        retire_rd_o    <= com_i.rd;
        retire_wdata_o <= com_i.result;
        retire_cause_o <= '0;
      end
    end
  end

endmodule

// ==== source/mini_core.sv ====
/*
 * mini core top level
 * three stage in-order integer pipeline
 */
`timescale 1ns/1ps

module mini_core (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               instr_valid_i,
  input  core_pkg::instr_t   instr_i,
  output logic               instr_ready_o,
  output logic               retire_valid_o,
  output logic               retire_exc_o,
  output core_pkg::addr_t    retire_pc_o,
  output core_pkg::reg_idx_t retire_rd_o,
  output core_pkg::xlen_t    retire_wdata_o,
  output core_pkg::instr_t   retire_tval_o,
  output core_pkg::cause_t   retire_cause_o,
  output core_pkg::xlen_t    instret_o
);

  dec_exe_if dec_exe ();
  rf_read_if rf_read ();
  exe_com_if exe_com ();

  decode_stage u_decode (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .instr_valid_i ( instr_valid_i ),
    .instr_i       ( instr_i       ),
    .instr_ready_o ( instr_ready_o ),
    .dec_o         ( dec_exe       )
  );

  execute_stage u_execute (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .dec_i  ( dec_exe ),
    .rf_o   ( rf_read ),
    .com_o  ( exe_com )
  );

  commit_stage u_commit (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .com_i          ( exe_com        ),
    .rf_i           ( rf_read        ),
    .retire_valid_o ( retire_valid_o ),
    .retire_exc_o   ( retire_exc_o   ),
    .retire_pc_o    ( retire_pc_o    ),
    .retire_rd_o    ( retire_rd_o    ),
    .retire_wdata_o ( retire_wdata_o ),
    .retire_tval_o  ( retire_tval_o  ),
    .retire_cause_o ( retire_cause_o ),
    .instret_o      ( instret_o      )
  );

endmodule

// ==== bench/retire_checker.sv ====
/*
 * retire checker
 * tracks accepted instructions and compares every retirement
 */
`timescale 1ns/1ps
`include "core_settings.svh"

module retire_checker (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               instr_valid_i,
  input  logic               instr_ready_i,
  input  core_pkg::instr_t   instr_i,
  input  int                 exp_test_i,
  input  core_pkg::reg_idx_t exp_rd_i,
  input  core_pkg::xlen_t    exp_wdata_i,
  input  logic               exp_exc_i,
  input  logic               retire_valid_i,
  input  logic               retire_exc_i,
  input  core_pkg::addr_t    retire_pc_i,
  input  core_pkg::reg_idx_t retire_rd_i,
  input  core_pkg::xlen_t    retire_wdata_i,
  input  core_pkg::instr_t   retire_tval_i,
  input  core_pkg::cause_t   retire_cause_i,
  input  core_pkg::xlen_t    instret_i,
  input  core_pkg::xlen_t    exp_instret_i,
  input  logic               finish_i,
  output int                 pending_o,
  output int                 errors_o,
  output logic               done_o
);
  import core_pkg::*;

  // one accepted instruction and what its retirement must show
  typedef struct packed {
    logic [31:0] test;
    addr_t       pc;
    reg_idx_t    rd;
    xlen_t       wdata;
    logic        exc;
    instr_t      instr;
  } expect_t;

  expect_t exp_q [$];
  expect_t entry;
  int      accepted;
  int      cur_test;
  bit      test_open;
  int      test_count;
  int      test_errs;
  int      tests_passed;
  int      tests_failed;
  int      drain_left;

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    if (got !== want) begin
      $display("FAIL %s: got 0x%08h, expected 0x%08h (test %0d, pc 0x%08h)",
               name, got, want, cur_test, retire_pc_i);
      test_errs++;
      errors_o++;
    end
  endtask

  task automatic report_test();
    if (test_errs == 0) begin
      tests_passed++;
      $display("test %0d passed, %0d instructions", cur_test, test_count);
    end else begin
      tests_failed++;
      $display("test %0d failed, %0d mismatches in %0d instructions",
               cur_test, test_errs, test_count);
    end
    test_open = 1'b0;
  endtask

  task automatic check_retire();
    expect_t head;
    if (exp_q.size() == 0) begin
      $display("retirement at pc 0x%08h with no accepted instruction outstanding",
               retire_pc_i);
      errors_o++;
    end else begin
      head = exp_q.pop_front();
      // a new test number closes the previous test
      if (!test_open || head.test != cur_test) begin
        if (test_open) begin
          report_test();
        end
        cur_test   = head.test;
        test_open  = 1'b1;
        test_count = 0;
        test_errs  = 0;
      end
      test_count++;
      compare_field("retire_pc_o", retire_pc_i, head.pc);
      compare_field("retire_exc_o", retire_exc_i, head.exc);
      compare_field("retire_rd_o", retire_rd_i, head.rd);
      compare_field("retire_wdata_o", retire_wdata_i, head.wdata);
      if (head.exc) begin
        compare_field("retire_cause_o", retire_cause_i, `CAUSE_ILLEGAL);
        compare_field("retire_tval_o", retire_tval_i, head.instr);
        // ready is back once the illegal instruction retires
        compare_field("instr_ready_o", instr_ready_i, 1'b1);
      end
    end
  endtask

  task automatic close_run();
    if (test_open) begin
      report_test();
    end
    if (instret_i !== exp_instret_i) begin
      $display("FAIL instret_o: got 0x%08h, expected 0x%08h", instret_i, exp_instret_i);
      errors_o++;
      tests_failed++;
      $display("instret check failed");
    end else begin
      tests_passed++;
      $display("instret check passed, %0d retirements", instret_i);
    end
    $display("tests passed %0d, tests failed %0d, total mismatches %0d",
             tests_passed, tests_failed, errors_o);
    done_o = 1'b1;
  endtask

  // inputs settle on the falling edge and are sampled here
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      exp_q.delete();
      accepted     = 0;
      cur_test     = 0;
      test_open    = 1'b0;
      test_count   = 0;
      test_errs    = 0;
      tests_passed = 0;
      tests_failed = 0;
      drain_left   = 0;
      pending_o    = 0;
      errors_o     = 0;
      done_o       = 1'b0;
    end else if (!done_o) begin
      // ready stays low while an illegal instruction drains
      if (drain_left > 0) begin
        if (instr_ready_i !== 1'b0) begin
          $display("FAIL instr_ready_o: got 0x%0h, expected 0x0 while draining",
                   instr_ready_i);
          errors_o++;
        end
        drain_left--;
      end
      if (instr_valid_i && instr_ready_i) begin
        entry.test  = exp_test_i;
        entry.pc    = `BOOT_ADDR + 4 * accepted;
        entry.rd    = exp_rd_i;
        entry.wdata = exp_wdata_i;
        entry.exc   = exp_exc_i;
        entry.instr = instr_i;
        exp_q.push_back(entry);
        accepted++;
        if (exp_exc_i) begin
          drain_left = 2;
        end
      end
      if (retire_valid_i) begin
        check_retire();
      end
      if (finish_i) begin
        close_run();
      end
      pending_o = exp_q.size();
    end
  end

endmodule

// ==== bench/tb_mini_core.sv ====
/*
 * mini core testbench
 * drives instructions from the data file and waits for the checker
 */
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_mini_core;
  import core_pkg::*;

  localparam int unsigned SEED            = 32'h3fac_f4b7;
  localparam int          RESET_CYCLES    = 16;
  localparam int          CYCLES_PER_LINE = 20;
  // bypass and x0 tests issue without gaps
  localparam int          TIGHT_FIRST     = 3;
  localparam int          TIGHT_LAST      = 4;

  logic     clk;
  logic     rst_n;
  logic     instr_valid;
  instr_t   instr;
  logic     instr_ready;
  logic     retire_valid;
  logic     retire_exc;
  addr_t    retire_pc;
  reg_idx_t retire_rd;
  xlen_t    retire_wdata;
  instr_t   retire_tval;
  cause_t   retire_cause;
  xlen_t    instret;

  int       exp_test;
  reg_idx_t exp_rd;
  xlen_t    exp_wdata;
  logic     exp_exc;
  xlen_t    exp_instret;
  logic     finish;
  int       pending;
  int       errors;
  logic     checker_done;
  bit       lines_ready;

  // one entry per data line
  int       line_test  [$];
  instr_t   line_instr [$];
  reg_idx_t line_rd    [$];
  xlen_t    line_wdata [$];
  logic     line_exc   [$];

  mini_core dut0 (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .instr_valid_i  ( instr_valid  ),
    .instr_i        ( instr        ),
    .instr_ready_o  ( instr_ready  ),
    .retire_valid_o ( retire_valid ),
    .retire_exc_o   ( retire_exc   ),
    .retire_pc_o    ( retire_pc    ),
    .retire_rd_o    ( retire_rd    ),
    .retire_wdata_o ( retire_wdata ),
    .retire_tval_o  ( retire_tval  ),
    .retire_cause_o ( retire_cause ),
    .instret_o      ( instret      )
  );

  retire_checker chk0 (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .instr_valid_i  ( instr_valid  ),
    .instr_ready_i  ( instr_ready  ),
    .instr_i        ( instr        ),
    .exp_test_i     ( exp_test     ),
    .exp_rd_i       ( exp_rd       ),
    .exp_wdata_i    ( exp_wdata    ),
    .exp_exc_i      ( exp_exc      ),
    .retire_valid_i ( retire_valid ),
    .retire_exc_i   ( retire_exc   ),
    .retire_pc_i    ( retire_pc    ),
    .retire_rd_i    ( retire_rd    ),
    .retire_wdata_i ( retire_wdata ),
    .retire_tval_i  ( retire_tval  ),
    .retire_cause_i ( retire_cause ),
    .instret_i      ( instret      ),
    .exp_instret_i  ( exp_instret  ),
    .finish_i       ( finish       ),
    .pending_o      ( pending      ),
    .errors_o       ( errors       ),
    .done_o         ( checker_done )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  task automatic load_lines();
    int          fd;
    int          t;
    logic [31:0] word;
    int          rd;
    logic [31:0] wdata;
    int          exc;
    fd = $fopen("bench/core_input.txt", "r");
    if (fd != 0) begin
      // test, instruction, rd, wdata, exception flag
      while ($fscanf(fd, "%d %h %d %h %d", t, word, rd, wdata, exc) == 5) begin
        line_test.push_back(t);
        line_instr.push_back(word);
        line_rd.push_back(rd[4:0]);
        line_wdata.push_back(wdata);
        line_exc.push_back(exc != 0);
      end
      $fclose(fd);
    end
  endtask

  // random gap, then hold the line until the core accepts it
  task automatic send_line(input int idx);
    int idle;
    idle = 0;
    if (line_test[idx] < TIGHT_FIRST || line_test[idx] > TIGHT_LAST) begin
      idle = $urandom % 3;
    end
    repeat (idle) begin
      @(negedge clk);
      instr_valid = 1'b0;
      @(posedge clk);
    end
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = line_instr[idx];
    exp_test    = line_test[idx];
    exp_rd      = line_rd[idx];
    exp_wdata   = line_wdata[idx];
    exp_exc     = line_exc[idx];
    @(posedge clk);
    while (!instr_ready) begin
      @(posedge clk);
    end
  endtask

  task automatic abort_run();
    $display("Errors found");
    $finish;
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    int unsigned seed;
    int          n_ok;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    exp_test    = 0;
    exp_rd      = '0;
    exp_wdata   = '0;
    exp_exc     = 1'b0;
    exp_instret = '0;
    finish      = 1'b0;
    seed        = SEED;
    void'($urandom(seed));
    load_lines();
    if (line_test.size() == 0) begin
      $display("no instruction lines could be read from bench/core_input.txt");
      abort_run();
    end else begin
      lines_ready = 1'b1;
      n_ok = 0;
      foreach (line_exc[i]) begin
        if (!line_exc[i]) begin
          n_ok++;
        end
      end
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int idx = 0; idx < line_test.size(); idx++) begin
        send_line(idx);
      end
      @(negedge clk);
      instr_valid = 1'b0;
      while (pending != 0) begin
        @(negedge clk);
      end
      exp_instret = n_ok;
      finish      = 1'b1;
      @(negedge clk);
      while (!checker_done) begin
        @(negedge clk);
      end
      if (errors == 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
      $finish;
    end
  end

  // watchdog
  initial begin
    int limit;
    wait (lines_ready);
    limit = RESET_CYCLES + CYCLES_PER_LINE * line_test.size();
    repeat (limit) @(posedge clk);
    $display("timeout, the run did not finish within %0d cycles", limit);
    abort_run();
  end

endmodule

// ==== list.f ====
+incdir+source
source/core_pkg.sv
source/stage_if.sv
source/decode_stage.sv
source/execute_stage.sv
source/commit_stage.sv
source/mini_core.sv
bench/retire_checker.sv
bench/tb_mini_core.sv

// ==== Bender.yml ====
package:
  name: mini_core

sources:
  - include_dirs:
      - source
    files:
      - source/core_pkg.sv
      - source/stage_if.sv
      - source/decode_stage.sv
      - source/execute_stage.sv
      - source/commit_stage.sv
      - source/mini_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/retire_checker.sv
      - bench/tb_mini_core.sv

// ==== bench/core_input.txt ====
1 00500093 1 00000005 0
1 ffd00113 2 fffffffd 0
1 800001b7 3 80000000 0
1 4041d993 19 f8000000 0
2 00208233 4 00000002 0
2 402082b3 5 00000008 0
2 0020f333 6 00000005 0
2 0020e3b3 7 fffffffd 0
2 0020c433 8 fffffff8 0
2 001124b3 9 00000001 0
2 00113533 10 00000000 0
2 001095b3 11 000000a0 0
2 0011d633 12 04000000 0
2 4011d6b3 13 fc000000 0
3 00700713 14 00000007 0
3 00170713 14 00000008 0
3 00e707b3 15 00000010 0
3 40e78833 16 00000008 0
4 00908013 0 0000000e 0
4 001008b3 17 00000005 0
5 021080b3 0 00000000 1
5 00008913 18 00000005 0
